// ==== design/cplx_pkg.sv ====
package cplx_pkg;

  // operation select carried with every request
  typedef enum logic [1:0] {
    // a + b
    OP_ADD  = 2'd0,
    // a - b
    OP_SUB  = 2'd1,
    // a * b
    OP_MUL  = 2'd2,
    // a * conj(b)
    OP_CMUL = 2'd3
  } cplx_op_e;

  // saturation flags returned with each result
  typedef struct packed {
    // real part was clamped
    logic ovf_re;
    // imaginary part was clamped
    logic ovf_im;
  } cplx_status_t;

  // register stages between request accept and response valid
  localparam int PIPE_DEPTH = 2;

endpackage

// ==== design/cplx_stream_if.sv ====
`timescale 1ns/100ps

// valid/ready stream, one transfer per clock with valid and ready high
interface cplx_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;

  // producer side
  modport src (
    output valid,
    output data,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  data,
    output ready
  );

endinterface

// ==== design/cplx_addsub.sv ====
`timescale 1ns/100ps

module cplx_addsub #(
  parameter int DATA_W = 16
) (
  input  logic                     clk_i,
  cplx_stream_if.dst               req,
  input  logic                     s1_en_i,
  output logic signed [DATA_W:0]   sum_re_o,
  output logic signed [DATA_W:0]   sum_im_o
);

  import cplx_pkg::*;

  logic signed [DATA_W-1:0] ar;
  logic signed [DATA_W-1:0] ai;
  logic signed [DATA_W-1:0] br;
  logic signed [DATA_W-1:0] bi;
  logic signed [DATA_W:0]   nxt_re;
  logic signed [DATA_W:0]   nxt_im;

  assign ar = req.data.ar;
  assign ai = req.data.ai;
  assign br = req.data.br;
  assign bi = req.data.bi;

  // one guard bit, so the sum is exact
  always_comb begin
    if (req.data.op == OP_SUB) begin
      nxt_re = ar - br;
      nxt_im = ai - bi;
    end else begin
      nxt_re = ar + br;
      nxt_im = ai + bi;
    end
  end

  // clamping to DATA_W happens in stage 2
  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      sum_re_o <= nxt_re;
      sum_im_o <= nxt_im;
    end
  end

endmodule

// ==== design/cplx_mul.sv ====
`timescale 1ns/100ps

module cplx_mul #(
  parameter int DATA_W = 16
) (
  input  logic                       clk_i,
  cplx_stream_if.dst                 req,
  input  logic                       s1_en_i,
  output logic signed [2*DATA_W:0]   prod_re_o,
  output logic signed [2*DATA_W:0]   prod_im_o
);

  import cplx_pkg::*;

  localparam int PROD_W = 2*DATA_W + 1;

  logic signed [DATA_W-1:0]   ar;
  logic signed [DATA_W-1:0]   ai;
  logic signed [DATA_W-1:0]   br;
  logic signed [DATA_W-1:0]   bi;
  logic signed [2*DATA_W-1:0] p_rr;
  logic signed [2*DATA_W-1:0] p_ii;
  logic signed [2*DATA_W-1:0] p_ir;
  logic signed [2*DATA_W-1:0] p_ri;
  logic signed [PROD_W-1:0]   nxt_re;
  logic signed [PROD_W-1:0]   nxt_im;

  assign ar = req.data.ar;
  assign ai = req.data.ai;
  assign br = req.data.br;
  assign bi = req.data.bi;

  // partial products, full precision
  assign p_rr = ar * br;
  assign p_ii = ai * bi;
  assign p_ir = ai * br;
  assign p_ri = ar * bi;

  // conj(b) flips the sign of every bi term
  always_comb begin
    if (req.data.op == OP_CMUL) begin
      nxt_re = p_rr + p_ii;
      nxt_im = p_ir - p_ri;
    end else begin
      nxt_re = p_rr - p_ii;
      nxt_im = p_ir + p_ri;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      prod_re_o <= nxt_re;
      prod_im_o <= nxt_im;
    end
  end

  // magnitude of a sum of two products is at most 2**(2*DATA_W-1)
  function automatic logic fits_prod(input logic signed [PROD_W-1:0] v);
    return (v[PROD_W-1] == v[PROD_W-2]) || (v[PROD_W-3:0] == '0);
  endfunction

  a_prod_growth: assert property (
    @(posedge clk_i) s1_en_i |-> fits_prod(nxt_re) && fits_prod(nxt_im)
  ) else $error("product sum exceeds expected growth");

endmodule

// ==== design/cplx_round_sat.sv ====
`timescale 1ns/100ps

module cplx_round_sat #(
  parameter int DATA_W = 16,
  parameter int FRAC_W = 15
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       s2_en_i,
  input  cplx_pkg::cplx_op_e         s1_op_i,
  input  logic signed [DATA_W:0]     sum_re_i,
  input  logic signed [DATA_W:0]     sum_im_i,
  input  logic signed [2*DATA_W:0]   prod_re_i,
  input  logic signed [2*DATA_W:0]   prod_im_i,
  cplx_stream_if.src                 rsp
);

  import cplx_pkg::*;

  // one extra bit over the product so the rounding add never wraps
  localparam int WIDE_W = 2*DATA_W + 2;
  localparam logic signed [WIDE_W-1:0] HALF = (WIDE_W'(1) << FRAC_W) >> 1;
  localparam logic signed [WIDE_W-1:0] MAX_V = {{(WIDE_W-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
  localparam logic signed [WIDE_W-1:0] MIN_V = {{(WIDE_W-DATA_W+1){1'b1}}, {(DATA_W-1){1'b0}}};

  logic                     is_mul;
  logic signed [WIDE_W-1:0] wide_re;
  logic signed [WIDE_W-1:0] wide_im;
  logic [DATA_W:0]          sat_re;
  logic [DATA_W:0]          sat_im;

  // result is {flag, value}
  function automatic logic [DATA_W:0] clamp(input logic signed [WIDE_W-1:0] v);
    logic [DATA_W:0] res;
    if (v > MAX_V) begin
      res = {1'b1, MAX_V[DATA_W-1:0]};
    end else if (v < MIN_V) begin
      res = {1'b1, MIN_V[DATA_W-1:0]};
    end else begin
      res = {1'b0, v[DATA_W-1:0]};
    end
    return res;
  endfunction

  assign is_mul = (s1_op_i == OP_MUL) || (s1_op_i == OP_CMUL);

  // round half up, then drop the extra fraction bits
  always_comb begin
    if (is_mul) begin
      wide_re = (prod_re_i + HALF) >>> FRAC_W;
      wide_im = (prod_im_i + HALF) >>> FRAC_W;
    end else begin
      wide_re = sum_re_i;
      wide_im = sum_im_i;
    end
  end

  assign sat_re = clamp(wide_re);
  assign sat_im = clamp(wide_im);

  // response register drives the top outputs directly
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp.data <= '0;
    end else if (s2_en_i) begin
      rsp.data.re            <= sat_re[DATA_W-1:0];
      rsp.data.im            <= sat_im[DATA_W-1:0];
      rsp.data.status.ovf_re <= sat_re[DATA_W];
      rsp.data.status.ovf_im <= sat_im[DATA_W];
    end
  end

endmodule

// ==== design/cplx_pipe_ctrl.sv ====
`timescale 1ns/100ps

module cplx_pipe_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                flush_i,
  cplx_stream_if.dst          req,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                s1_en_o,
  output logic                s2_en_o,
  output cplx_pkg::cplx_op_e  s1_op_o,
  output logic                busy_o
);

  import cplx_pkg::*;

  logic s1_valid;
  logic s2_valid;
  // stage can take a new item this cycle
  logic s1_adv;
  logic s2_adv;

  assign s2_adv = !s2_valid || out_ready_i;
  assign s1_adv = !s1_valid || s2_adv;

  // no accept while flushing
  assign req.ready = s1_adv && !flush_i;
  assign s1_en_o   = req.valid && req.ready;
  assign s2_en_o   = s1_valid && s2_adv && !flush_i;

  assign out_valid_o = s2_valid;
  assign busy_o      = s1_valid || s2_valid;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_adv) begin
        s1_valid <= s1_en_o;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // steers the stage-2 path select
  always_ff @(posedge clk_i) begin
    if (s1_en_o) begin
      s1_op_o <= req.data.op;
    end
  end

  // a pending response is held until taken or flushed
  a_out_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o
  ) else $error("out_valid_o dropped without a transfer");

  // upstream must keep in_valid low while reset is held
  a_no_load_in_reset: assert property (
    @(posedge clk_i) $past(rst_i) && rst_i |-> !s1_en_o && !s2_en_o
  ) else $error("stage load during reset");

endmodule

// ==== design/cplx_alu_top.sv ====
`timescale 1ns/100ps

module cplx_alu_top #(
  parameter int DATA_W = 16,
  parameter int FRAC_W = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // request side
  input  logic                     in_valid_i,
  input  cplx_pkg::cplx_op_e       in_op_i,
  input  logic signed [DATA_W-1:0] ar_i,
  input  logic signed [DATA_W-1:0] ai_i,
  input  logic signed [DATA_W-1:0] br_i,
  input  logic signed [DATA_W-1:0] bi_i,
  output logic                     in_ready_o,
  // response side
  output logic                     out_valid_o,
  output logic signed [DATA_W-1:0] out_re_o,
  output logic signed [DATA_W-1:0] out_im_o,
  output cplx_pkg::cplx_status_t   out_status_o,
  input  logic                     out_ready_i,
  // items in flight
  output logic                     busy_o
);

  import cplx_pkg::*;

  typedef struct packed {
    cplx_op_e                 op;
    logic signed [DATA_W-1:0] ar;
    logic signed [DATA_W-1:0] ai;
    logic signed [DATA_W-1:0] br;
    logic signed [DATA_W-1:0] bi;
  } cplx_req_t;

  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
    cplx_status_t             status;
  } cplx_rsp_t;

  logic                     s1_en;
  logic                     s2_en;
  cplx_op_e                 s1_op;
  logic signed [DATA_W:0]   sum_re;
  logic signed [DATA_W:0]   sum_im;
  logic signed [2*DATA_W:0] prod_re;
  logic signed [2*DATA_W:0] prod_im;

  cplx_stream_if #(.payload_t(cplx_req_t)) req_if ();
  cplx_stream_if #(.payload_t(cplx_rsp_t)) rsp_if ();

  assign req_if.valid = in_valid_i;
  assign req_if.data  = cplx_req_t'{op: in_op_i, ar: ar_i, ai: ai_i, br: br_i, bi: bi_i};
  assign in_ready_o   = req_if.ready;

  assign rsp_if.ready = out_ready_i;
  assign out_valid_o  = rsp_if.valid;
  assign out_re_o     = rsp_if.data.re;
  assign out_im_o     = rsp_if.data.im;
  assign out_status_o = rsp_if.data.status;

  cplx_pipe_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .req         (req_if),
    .out_valid_o (rsp_if.valid),
    .out_ready_i (rsp_if.ready),
    .s1_en_o     (s1_en),
    .s2_en_o     (s2_en),
    .s1_op_o     (s1_op),
    .busy_o      (busy_o)
  );

  cplx_addsub #(.DATA_W(DATA_W)) u_addsub (
    .clk_i    (clk_i),
    .req      (req_if),
    .s1_en_i  (s1_en),
    .sum_re_o (sum_re),
    .sum_im_o (sum_im)
  );

  cplx_mul #(.DATA_W(DATA_W)) u_mul (
    .clk_i     (clk_i),
    .req       (req_if),
    .s1_en_i   (s1_en),
    .prod_re_o (prod_re),
    .prod_im_o (prod_im)
  );

  cplx_round_sat #(
    .DATA_W (DATA_W),
    .FRAC_W (FRAC_W)
  ) u_round_sat (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s2_en_i   (s2_en),
    .s1_op_i   (s1_op),
    .sum_re_i  (sum_re),
    .sum_im_i  (sum_im),
    .prod_re_i (prod_re),
    .prod_im_i (prod_im),
    .rsp       (rsp_if)
  );

endmodule

// ==== include/cplx_tb_checks.svh ====
`ifndef CPLX_TB_CHECKS_SVH
`define CPLX_TB_CHECKS_SVH

// totals for the closing summary
int pass_count = 0;
int err_count  = 0;

// both parts of a response, compared as DATA_W-bit values
task automatic check_rsp(
  input string             tag,
  input logic [DATA_W-1:0] exp_re,
  input logic [DATA_W-1:0] exp_im,
  input logic [DATA_W-1:0] act_re,
  input logic [DATA_W-1:0] act_im
);
  if (act_re !== exp_re) begin
    $display("[ERROR] out_re_o (%s): expected %h, got %h", tag, exp_re, act_re);
    err_count++;
  end else begin
    pass_count++;
  end
  if (act_im !== exp_im) begin
    $display("[ERROR] out_im_o (%s): expected %h, got %h", tag, exp_im, act_im);
    err_count++;
  end else begin
    pass_count++;
  end
endtask

task automatic check_status(
  input string        tag,
  input cplx_status_t exp_st,
  input cplx_status_t act_st
);
  if (act_st !== exp_st) begin
    $display("[ERROR] out_status_o (%s): expected %h, got %h", tag, exp_st, act_st);
    err_count++;
  end else begin
    pass_count++;
  end
endtask

`endif

// ==== test/cplx_alu_tb.sv ====
`timescale 1ns/100ps

module cplx_alu_tb;

  import cplx_pkg::*;

  localparam int DATA_W   = 16;
  localparam int FRAC_W   = 15;
  localparam int N_ADDSUB = 300;
  localparam int N_MUL    = 300;
  localparam int N_BP     = 300;
  localparam int N_THRU   = 100;
  localparam int N_FLUSH  = 50;
  // extra items: -1 * -1, two flushed, one offered during flush
  localparam int TOTAL_REQ   = N_ADDSUB + N_MUL + N_BP + N_THRU + N_FLUSH + 4;
  localparam int TIMEOUT_CYC = 4*TOTAL_REQ + 200;
  localparam logic [DATA_W-1:0] MAX_V = {1'b0, {(DATA_W-1){1'b1}}};
  localparam logic [DATA_W-1:0] MIN_V = {1'b1, {(DATA_W-1){1'b0}}};
  localparam longint HI_V = (longint'(1) << (DATA_W-1)) - 1;
  localparam longint LO_V = -HI_V - 1;

  typedef struct packed {
    logic [DATA_W-1:0] re;
    logic [DATA_W-1:0] im;
    cplx_status_t      status;
  } exp_rsp_t;

  logic clk_i = 1'b0;
  logic rst_i;
  logic flush_i;
  logic in_valid_i;
  logic in_ready_o;
  logic out_ready_i;
  logic out_valid_o;
  logic busy_o;
  cplx_op_e in_op_i;
  logic signed [DATA_W-1:0] ar_i;
  logic signed [DATA_W-1:0] ai_i;
  logic signed [DATA_W-1:0] br_i;
  logic signed [DATA_W-1:0] bi_i;
  logic signed [DATA_W-1:0] out_re_o;
  logic signed [DATA_W-1:0] out_im_o;
  cplx_status_t out_status_o;

  // expected responses and the cycle each request was taken
  exp_rsp_t exp_q[$];
  int       acc_cyc_q[$];
  int       acc_cnt = 0;
  int       cycle_cnt = 0;
  bit       lat_check_on = 1'b0;
  bit       prev_stall = 1'b0;
  exp_rsp_t held;

  `include "cplx_tb_checks.svh"

  cplx_alu_top #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) UUT (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .flush_i(flush_i),
    .in_valid_i(in_valid_i),
    .in_op_i(in_op_i),
    .ar_i(ar_i),
    .ai_i(ai_i),
    .br_i(br_i),
    .bi_i(bi_i),
    .in_ready_o(in_ready_o),
    .out_valid_o(out_valid_o),
    .out_re_o(out_re_o),
    .out_im_o(out_im_o),
    .out_status_o(out_status_o),
    .out_ready_i(out_ready_i),
    .busy_o(busy_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic longint round_frac(input longint v);
    if (FRAC_W == 0) return v;
    return (v + (longint'(1) << (FRAC_W - 1))) >>> FRAC_W;
  endfunction

  function automatic exp_rsp_t model_rsp(input cplx_op_e op,
      input logic signed [DATA_W-1:0] ar, ai, br, bi);
    longint xr = ar;
    longint xi = ai;
    longint yr = br;
    longint yi = bi;
    longint re_w;
    longint im_w;
    exp_rsp_t r;
    case (op)
      OP_ADD: begin
        re_w = xr + yr;
        im_w = xi + yi;
      end
      OP_SUB: begin
        re_w = xr - yr;
        im_w = xi - yi;
      end
      OP_MUL: begin
        re_w = round_frac(xr*yr - xi*yi);
        im_w = round_frac(xi*yr + xr*yi);
      end
      default: begin
        re_w = round_frac(xr*yr + xi*yi);
        im_w = round_frac(xi*yr - xr*yi);
      end
    endcase
    r.re = (re_w > HI_V) ? MAX_V : (re_w < LO_V) ? MIN_V : re_w[DATA_W-1:0];
    r.im = (im_w > HI_V) ? MAX_V : (im_w < LO_V) ? MIN_V : im_w[DATA_W-1:0];
    r.status.ovf_re = (re_w > HI_V) || (re_w < LO_V);
    r.status.ovf_im = (im_w > HI_V) || (im_w < LO_V);
    return r;
  endfunction

  // full-scale values now and then so clamping gets exercised
  function automatic logic [DATA_W-1:0] pick_operand();
    int sel = $urandom % 8;
    if (sel == 0) return MAX_V;
    if (sel == 1) return MIN_V;
    return $urandom;
  endfunction

  task automatic note_failure(input string msg);
    $display("failure: %s", msg);
    err_count++;
  endtask

  task automatic load_random(input int base, input int span);
    in_op_i = cplx_op_e'(base + $urandom % span);
    ar_i = pick_operand();
    ai_i = pick_operand();
    br_i = pick_operand();
    bi_i = pick_operand();
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic wait_accept();
    int start = acc_cnt;
    in_valid_i = 1'b1;
    @(negedge clk_i);
    while (acc_cnt == start) @(negedge clk_i);
  endtask

  task automatic drain();
    in_valid_i = 1'b0;
    while (exp_q.size() != 0 || busy_o) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int n_req, input int err0);
    $display("test %-12s done: %0d requests, %0d errors", name, n_req, err_count - err0);
  endtask

  // handshake monitor, reference model and timeout
  always @(posedge clk_i) begin
    exp_rsp_t e;
    int c0;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      if (!rst_i) begin
        if (prev_stall && !out_valid_o) note_failure("out_valid_o dropped while stalled");
        if (prev_stall && out_valid_o) begin
          check_rsp("held", held.re, held.im, out_re_o, out_im_o);
          check_status("held", held.status, out_status_o);
        end
        if (out_valid_o && out_ready_i) begin
          if (exp_q.size() == 0) begin
            note_failure("response with no outstanding request");
          end else begin
            e = exp_q.pop_front();
            c0 = acc_cyc_q.pop_front();
            check_rsp("result", e.re, e.im, out_re_o, out_im_o);
            check_status("result", e.status, out_status_o);
            if (lat_check_on && cycle_cnt - c0 != PIPE_DEPTH)
              note_failure($sformatf("latency %0d cycles", cycle_cnt - c0));
          end
        end
        // in-flight items never come out after a flush
        if (flush_i) begin
          exp_q.delete();
          acc_cyc_q.delete();
        end
        if (in_valid_i && in_ready_o) begin
          exp_q.push_back(model_rsp(in_op_i, ar_i, ai_i, br_i, bi_i));
          acc_cyc_q.push_back(cycle_cnt);
          acc_cnt++;
        end
        if (lat_check_on && in_valid_i && !in_ready_o)
          note_failure("in_ready_o fell during full-rate traffic");
        prev_stall = out_valid_o && !out_ready_i && !flush_i;
        held = {out_re_o, out_im_o, out_status_o};
      end
      cycle_cnt++;
    end
  end

  initial begin
    int err0;
    int issued;
    int start;
    void'($urandom(32'h593c));
    rst_i = 1'b1;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    in_op_i = OP_ADD;
    ar_i = '0;
    ai_i = '0;
    br_i = '0;
    bi_i = '0;
    out_ready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    err0 = err_count;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1)
      note_failure("outputs not idle after reset");
    report_test("reset_state", 0, err0);

    err0 = err_count;
    out_ready_i = 1'b1;
    repeat (N_ADDSUB) begin
      load_random(0, 2);
      wait_accept();
    end
    drain();
    report_test("add_sub", N_ADDSUB, err0);

    // -1 times -1 overflows to +1
    err0 = err_count;
    in_op_i = OP_MUL;
    ar_i = MIN_V;
    ai_i = '0;
    br_i = MIN_V;
    bi_i = '0;
    wait_accept();
    repeat (N_MUL) begin
      load_random(2, 2);
      wait_accept();
    end
    drain();
    report_test("mul_cmul", N_MUL + 1, err0);

    err0 = err_count;
    issued = 0;
    start = 0;
    while (issued < N_BP) begin
      out_ready_i = $urandom % 2;
      if (!in_valid_i && ($urandom % 2)) begin
        load_random(0, 4);
        in_valid_i = 1'b1;
        start = acc_cnt;
      end
      @(negedge clk_i);
      if (in_valid_i && acc_cnt != start) begin
        in_valid_i = 1'b0;
        issued++;
      end
    end
    out_ready_i = 1'b1;
    drain();
    report_test("back_pressure", N_BP, err0);

    err0 = err_count;
    lat_check_on = 1'b1;
    repeat (N_THRU) begin
      load_random(0, 4);
      wait_accept();
    end
    drain();
    lat_check_on = 1'b0;
    report_test("throughput", N_THRU, err0);

    // fill both stages behind a stalled output, then flush
    err0 = err_count;
    out_ready_i = 1'b0;
    repeat (2) begin
      load_random(0, 4);
      wait_accept();
    end
    if (!out_valid_o || !busy_o || in_ready_o) note_failure("pipeline not full before flush");
    in_valid_i = 1'b0;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0) note_failure("pipeline not empty after flush");
    @(negedge clk_i);
    // empty pipe, so only the flush holds this request off
    load_random(0, 4);
    in_valid_i = 1'b1;
    start = acc_cnt;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    if (acc_cnt != start) note_failure("request accepted during flush");
    out_ready_i = 1'b1;
    repeat (N_FLUSH) begin
      load_random(0, 4);
      wait_accept();
    end
    drain();
    report_test("flush", N_FLUSH + 2, err0);

    $display("summary: %0d checks passed, %0d errors", pass_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
design/cplx_pkg.sv
design/cplx_stream_if.sv
design/cplx_addsub.sv
design/cplx_mul.sv
design/cplx_round_sat.sv
design/cplx_pipe_ctrl.sv
design/cplx_alu_top.sv
test/cplx_alu_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile: obj_dir/Vcplx_alu_tb

obj_dir/Vcplx_alu_tb: project.f $(wildcard design/*.sv test/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module cplx_alu_tb -Mdir obj_dir -o Vcplx_alu_tb

run: compile
	./obj_dir/Vcplx_alu_tb | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "simulation incomplete"; exit 1)

clean:
	rm -rf obj_dir sim.log
